/* rtl/crop_settings.svh */
`ifndef CROP_SETTINGS_SVH
`define CROP_SETTINGS_SVH

// pixel/line counters, offsets and sizes
`define CROP_CNT_W          12

`define CROP_H_STEP         4    // pixels per key press
`define CROP_V_STEP         1    // lines per key press

`define CROP_H_FORCE_LEAD   8    // forced hblank ends at this pixel
`define CROP_H_FORCE_TAIL   8    // forced hblank starts this far before line end
`define CROP_V_FORCE_LEAD   1
`define CROP_V_FORCE_TAIL   3

`define CROP_KEY_TYPE_ADJ   2'd3 // key type of an adjust key
`define CROP_FLAG_W         7

`endif

/* rtl/crop_pkg.sv */
`default_nettype none

package crop_pkg;

	`include "crop_settings.svh"

	// one word for every counter, offset and measured size
	typedef logic [`CROP_CNT_W-1:0] crop_cnt_t;

	// keyboard codes seen on the adjust path
	typedef enum logic [7:0] {
		KEY_CLEAR    = 8'h41, // backspace
		KEY_UP       = 8'h4c,
		KEY_DOWN     = 8'h4d,
		KEY_RIGHT    = 8'h4e,
		KEY_LEFT     = 8'h4f,
		KEY_ALT_L_DN = 8'h64,
		KEY_ALT_R_DN = 8'h65,
		KEY_ALT_L_UP = 8'he4,
		KEY_ALT_R_UP = 8'he5
	} key_cmd_e;

endpackage

`default_nettype wire

/* rtl/crop_if.sv */
`timescale 1ns/100ps
`default_nettype none

// the four edge offsets of the display window
interface crop_if;

	crop_pkg::crop_cnt_t hbl_l; // left edge, pixels
	crop_pkg::crop_cnt_t hbl_r; // right edge, pixels
	crop_pkg::crop_cnt_t vbl_t; // top edge, lines
	crop_pkg::crop_cnt_t vbl_b; // bottom edge, lines

	// key decoder owns the offsets
	modport keys (
		output hbl_l, hbl_r, vbl_t, vbl_b
	);

	// timing units and snapshot
	modport sink (
		input hbl_l, hbl_r, vbl_t, vbl_b
	);

endinterface

`default_nettype wire

/* rtl/margin_keys.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module margin_keys (
	input  logic       clk_28,
	input  logic       rst_n,
	input  logic [7:0] key_data,
	input  logic [1:0] key_type,
	input  logic       key_strobe,
	crop_if.keys       mgn
);

	logic                adj_stb;
	logic                stb_q;
	logic                stb_qq;
	logic                key_hit;
	logic [7:0]          key_q;
	logic                alt;

	assign adj_stb = key_strobe && (key_type == `CROP_KEY_TYPE_ADJ);
	assign key_hit = stb_q & ~stb_qq; // rising edge of the adjust strobe

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			stb_q  <= 1'b0;
			stb_qq <= 1'b0;
		end else begin
			stb_q  <= adj_stb;
			stb_qq <= stb_q;
		end
	end

	always_ff @(posedge clk_28) begin
		key_q <= key_data; // kept in step with stb_q
	end

	// offsets wrap at the counter width
	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			mgn.hbl_l <= '0;
			mgn.hbl_r <= '0;
			mgn.vbl_t <= '0;
			mgn.vbl_b <= '0;
			alt       <= 1'b0;
		end else if (key_hit) begin
			case (key_q)
				crop_pkg::KEY_CLEAR: begin
					mgn.hbl_l <= '0;
					mgn.hbl_r <= '0;
					mgn.vbl_t <= '0;
					mgn.vbl_b <= '0;
				end
				crop_pkg::KEY_UP: begin
					if (alt) mgn.vbl_b <= mgn.vbl_b + crop_pkg::crop_cnt_t'(`CROP_V_STEP);
					else     mgn.vbl_t <= mgn.vbl_t + crop_pkg::crop_cnt_t'(`CROP_V_STEP);
				end
				crop_pkg::KEY_DOWN: begin
					if (alt) mgn.vbl_b <= mgn.vbl_b - crop_pkg::crop_cnt_t'(`CROP_V_STEP);
					else     mgn.vbl_t <= mgn.vbl_t - crop_pkg::crop_cnt_t'(`CROP_V_STEP);
				end
				crop_pkg::KEY_LEFT: begin
					if (alt) mgn.hbl_r <= mgn.hbl_r + crop_pkg::crop_cnt_t'(`CROP_H_STEP);
					else     mgn.hbl_l <= mgn.hbl_l + crop_pkg::crop_cnt_t'(`CROP_H_STEP);
				end
				crop_pkg::KEY_RIGHT: begin
					if (alt) mgn.hbl_r <= mgn.hbl_r - crop_pkg::crop_cnt_t'(`CROP_H_STEP);
					else     mgn.hbl_l <= mgn.hbl_l - crop_pkg::crop_cnt_t'(`CROP_H_STEP);
				end
				crop_pkg::KEY_ALT_L_DN, crop_pkg::KEY_ALT_R_DN: alt <= 1'b1;
				crop_pkg::KEY_ALT_L_UP, crop_pkg::KEY_ALT_R_UP: alt <= 1'b0;
				default: ; // anything else is not ours
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/line_timing.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module line_timing (
	input  logic                clk_28,
	input  logic                rst_n,
	input  logic                hs_n,
	input  logic                hblank,
	crop_if.sink                mgn,
	output logic                hbl,
	output crop_pkg::crop_cnt_t hsize
);

	crop_pkg::crop_cnt_t hcnt;
	crop_pkg::crop_cnt_t hend;  // first active pixel of the source
	crop_pkg::crop_cnt_t hsta;  // first blanked pixel after the active part
	crop_pkg::crop_cnt_t hmax;  // line length as counted at hsync
	crop_pkg::crop_cnt_t open_at;
	crop_pkg::crop_cnt_t close_at;
	crop_pkg::crop_cnt_t force_on_at;
	logic                old_hs;
	logic                old_hblank;
	logic                shbl; // window blank
	logic                fhbl; // forced blank around sync

	// two cycles early for the blank register and de
	assign open_at      = hend + mgn.hbl_l - 2'd2;
	assign close_at     = hsta + mgn.hbl_r - 2'd2;
	assign force_on_at  = hmax - crop_pkg::crop_cnt_t'(`CROP_H_FORCE_TAIL);

	assign hbl = shbl | fhbl | ~hs_n;

	//////////////////////////////////////////////////////////////////////
	// pixel counter and source measurement
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
		end else begin
			old_hs     <= hs_n;
			old_hblank <= hblank;

			hcnt <= hcnt + 1'b1;
			if (!hs_n) hcnt <= '0; // held at zero through sync

			if (old_hblank & ~hblank) hend <= hcnt;
			if (~old_hblank & hblank) begin
				hsta  <= hcnt;
				hsize <= hcnt - hend;
			end
			if (old_hs & ~hs_n) hmax <= hcnt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// window and forced blank
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			shbl <= 1'b1;
			fhbl <= 1'b1;
		end else begin
			if (hcnt == open_at)  shbl <= 1'b0;
			if (hcnt == close_at) shbl <= 1'b1;

			if (hcnt == crop_pkg::crop_cnt_t'(`CROP_H_FORCE_LEAD)) fhbl <= 1'b0;
			if (hcnt == force_on_at)  fhbl <= 1'b1; // keeps hsync edge hidden
		end
	end

endmodule

`default_nettype wire

/* rtl/frame_timing.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module frame_timing (
	input  logic                clk_28,
	input  logic                rst_n,
	input  logic                hs_n,
	input  logic                vs_n,
	input  logic                vblank,
	input  logic                hbl,
	crop_if.sink                mgn,
	output logic                de,
	output crop_pkg::crop_cnt_t vsize
);

	crop_pkg::crop_cnt_t vcnt;
	crop_pkg::crop_cnt_t vend;  // last blank line before the active part
	crop_pkg::crop_cnt_t vsta;  // last active line
	crop_pkg::crop_cnt_t vmax;  // count at vsync
	crop_pkg::crop_cnt_t open_at;
	crop_pkg::crop_cnt_t close_at;
	crop_pkg::crop_cnt_t force_on_at;
	logic                old_hs;
	logic                old_vs;
	logic                old_vblank;
	logic                old_hbl;
	logic                hbl_fall;
	logic                svbl;
	logic                fvbl;
	logic                v_open; // vertical open for the current line

	// updated one line ahead so de picks it up on the next line
	assign open_at      = vend + mgn.vbl_t;
	assign close_at     = vsta + mgn.vbl_b;
	assign force_on_at  = vmax - crop_pkg::crop_cnt_t'(`CROP_V_FORCE_TAIL);

	assign hbl_fall = old_hbl & ~hbl;

	//////////////////////////////////////////////////////////////////////
	// line counter and frame measurement
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			old_hs     <= 1'b1;
			old_vs     <= 1'b1;
			old_vblank <= 1'b0;
			vcnt       <= '0;
			vend       <= '0;
			vsta       <= '0;
			vmax       <= '0;
			vsize      <= '0;
		end else begin
			old_hs     <= hs_n;
			old_vs     <= vs_n;
			old_vblank <= vblank;

			if (old_hs & ~hs_n) vcnt <= vcnt + 1'b1;
			if (!vs_n) vcnt <= '0;

			if (old_vblank & ~vblank) vend <= vcnt;
			if (~old_vblank & vblank) begin
				vsta  <= vcnt;
				vsize <= vcnt - vend;
			end
			if (old_vs & ~vs_n) vmax <= vcnt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// vertical window, forced blank and data enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			old_hbl <= 1'b1;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
			v_open  <= 1'b0;
			de      <= 1'b0;
		end else begin
			old_hbl <= hbl;

			// only at line start so a line is never cut in half
			if (hbl_fall) begin
				if (vcnt == open_at)  svbl <= 1'b0;
				if (vcnt == close_at) svbl <= 1'b1;

				if (vcnt == crop_pkg::crop_cnt_t'(`CROP_V_FORCE_LEAD)) fvbl <= 1'b0;
				if (vcnt == force_on_at)  fvbl <= 1'b1;

				v_open <= ~(svbl | fvbl); // held for the whole line
			end

			de <= ~hbl & (hbl_fall ? ~(svbl | fvbl) : v_open);
		end
	end

endmodule

`default_nettype wire

/* rtl/mode_tracker.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module mode_tracker (
	input  logic                   clk_28,
	input  logic                   rst_n,
	input  logic                   vblank,
	input  logic                   vs_n,
	input  logic [1:0]             res,
	input  crop_pkg::crop_cnt_t    hsize,
	input  crop_pkg::crop_cnt_t    vsize,
	crop_if.sink                   mgn,
	output crop_pkg::crop_cnt_t    scr_hbl_l,
	output crop_pkg::crop_cnt_t    scr_hbl_r,
	output crop_pkg::crop_cnt_t    scr_vbl_t,
	output crop_pkg::crop_cnt_t    scr_vbl_b,
	output crop_pkg::crop_cnt_t    scr_hsize,
	output crop_pkg::crop_cnt_t    scr_vsize,
	output logic [1:0]             scr_res,
	output logic [`CROP_FLAG_W-1:0] scr_flag
);

	logic blank;
	logic blank_q;
	logic blank_qq;
	logic take;

	assign blank = vblank | ~vs_n;
	assign take  = blank_qq & ~blank_q; // end of vertical blanking

	always_ff @(posedge clk_28 or negedge rst_n) begin
		if (!rst_n) begin
			blank_q   <= 1'b0;
			blank_qq  <= 1'b0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= '0;
			scr_flag  <= '0;
		end else begin
			blank_q  <= blank;
			blank_qq <= blank_q;
			if (take) begin
				scr_hbl_l <= mgn.hbl_l;
				scr_hbl_r <= mgn.hbl_r;
				scr_vbl_t <= mgn.vbl_t;
				scr_vbl_b <= mgn.vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				// mode change against the previous snapshot
				if (scr_res != res || scr_hsize != hsize || scr_vsize != vsize)
					scr_flag <= scr_flag + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/video_crop.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module video_crop (
	input  logic                    clk_28,
	input  logic                    rst_n,
	input  logic                    hs_n,
	input  logic                    vs_n,
	input  logic                    hblank,
	input  logic                    vblank,
	input  logic [1:0]              res,
	input  logic [7:0]              key_data,
	input  logic [1:0]              key_type,
	input  logic                    key_strobe,
	output logic                    de,
	output crop_pkg::crop_cnt_t     scr_hbl_l,
	output crop_pkg::crop_cnt_t     scr_hbl_r,
	output crop_pkg::crop_cnt_t     scr_vbl_t,
	output crop_pkg::crop_cnt_t     scr_vbl_b,
	output crop_pkg::crop_cnt_t     scr_hsize,
	output crop_pkg::crop_cnt_t     scr_vsize,
	output logic [1:0]              scr_res,
	output logic [`CROP_FLAG_W-1:0] scr_flag
);

	logic                hbl;   // combined horizontal blank
	crop_pkg::crop_cnt_t hsize;
	crop_pkg::crop_cnt_t vsize;

	crop_if mgn ();

	//////////////////////////////////////////////////////////////////////
	// key decode, raster timing, per-frame snapshot
	//////////////////////////////////////////////////////////////////////

	margin_keys u_margin_keys (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.key_data   (key_data),
		.key_type   (key_type),
		.key_strobe (key_strobe),
		.mgn        (mgn.keys)
	);

	line_timing u_line_timing (
		.clk_28 (clk_28),
		.rst_n  (rst_n),
		.hs_n   (hs_n),
		.hblank (hblank),
		.mgn    (mgn.sink),
		.hbl    (hbl),
		.hsize  (hsize)
	);

	frame_timing u_frame_timing (
		.clk_28 (clk_28),
		.rst_n  (rst_n),
		.hs_n   (hs_n),
		.vs_n   (vs_n),
		.vblank (vblank),
		.hbl    (hbl),
		.mgn    (mgn.sink),
		.de     (de),
		.vsize  (vsize)
	);

	mode_tracker u_mode_tracker (
		.clk_28    (clk_28),
		.rst_n     (rst_n),
		.vblank    (vblank),
		.vs_n      (vs_n),
		.res       (res),
		.hsize     (hsize),
		.vsize     (vsize),
		.mgn       (mgn.sink),
		.scr_hbl_l (scr_hbl_l),
		.scr_hbl_r (scr_hbl_r),
		.scr_vbl_t (scr_vbl_t),
		.scr_vbl_b (scr_vbl_b),
		.scr_hsize (scr_hsize),
		.scr_vsize (scr_vsize),
		.scr_res   (scr_res),
		.scr_flag  (scr_flag)
	);

endmodule

`default_nettype wire

/* test/tb_video_crop.sv */
`timescale 1ns/100ps
`default_nettype none
`include "crop_settings.svh"

module tb_video_crop;

	// source raster of 100 x 40 with 64 x 30 active
	localparam int LINE_LEN  = 100;
	localparam int HS_LEN    = 8;
	localparam int HB_END    = 20; // first active pixel
	localparam int HB_START  = 84;
	localparam int FRAME_LEN = 40;
	localparam int VS_LEN    = 2;
	localparam int VB_END    = 6;
	localparam int VB_START  = 36;
	localparam int FRAME_TMO = LINE_LEN * FRAME_LEN + 200;
	localparam int MAX_ROWS  = 12;
	localparam logic [1:0] ADJ = `CROP_KEY_TYPE_ADJ;
	localparam crop_pkg::crop_cnt_t SRC_W = crop_pkg::crop_cnt_t'(HB_START - HB_END);
	localparam crop_pkg::crop_cnt_t SRC_H = crop_pkg::crop_cnt_t'(VB_START - VB_END);

	typedef logic [`CROP_FLAG_W-1:0] flag_t;

	logic                clk_28;
	logic                rst_n;
	logic                hs_n;
	logic                vs_n;
	logic                hblank;
	logic                vblank;
	logic [1:0]          res;
	logic [7:0]          key_data;
	logic [1:0]          key_type;
	logic                key_strobe;
	logic                de;
	crop_pkg::crop_cnt_t scr_hbl_l;
	crop_pkg::crop_cnt_t scr_hbl_r;
	crop_pkg::crop_cnt_t scr_vbl_t;
	crop_pkg::crop_cnt_t scr_vbl_b;
	crop_pkg::crop_cnt_t scr_hsize;
	crop_pkg::crop_cnt_t scr_vsize;
	logic [1:0]          scr_res;
	flag_t               scr_flag;

	int px = 0;
	int ln = 0;
	int frame_cnt = 0;
	int mon_frame = 0;
	int run_len = 0;
	int run_cnt = 0;
	int run_min = 0;
	int run_max = 0;
	int frame_runs = 0; // de runs in the last whole frame, one per line
	int frame_min = 0;  // shortest de run in the last whole frame
	int frame_max = 0;
	int val_errors = 0;
	int tmo_errors = 0;
	int n_rows = 0;
	int r;
	integer seed;

	// key and expected-value table, one row per test
	logic [9:0]          row_keys [MAX_ROWS][4]; // {type, code}
	int                  row_nkeys [MAX_ROWS];
	logic [1:0]          row_res [MAX_ROWS];
	crop_pkg::crop_cnt_t row_off [MAX_ROWS][4]; // hbl_l, hbl_r, vbl_t, vbl_b
	crop_pkg::crop_cnt_t row_hsize [MAX_ROWS];
	crop_pkg::crop_cnt_t row_vsize [MAX_ROWS];
	int                  row_width [MAX_ROWS];
	int                  row_lines [MAX_ROWS];
	flag_t               row_finc [MAX_ROWS];

	video_crop u_video_crop (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.hs_n       (hs_n),
		.vs_n       (vs_n),
		.hblank     (hblank),
		.vblank     (vblank),
		.res        (res),
		.key_data   (key_data),
		.key_type   (key_type),
		.key_strobe (key_strobe),
		.de         (de),
		.scr_hbl_l  (scr_hbl_l),
		.scr_hbl_r  (scr_hbl_r),
		.scr_vbl_t  (scr_vbl_t),
		.scr_vbl_b  (scr_vbl_b),
		.scr_hsize  (scr_hsize),
		.scr_vsize  (scr_vsize),
		.scr_res    (scr_res),
		.scr_flag   (scr_flag)
	);

	initial begin
		clk_28 = 1'b0;
		forever #2 clk_28 = ~clk_28;
	end

	//////////////////////////////////////////////////////////////////////
	// raster generator and de monitor
	//////////////////////////////////////////////////////////////////////

	assign hs_n   = (px >= HS_LEN);
	assign hblank = (px < HB_END) || (px >= HB_START);
	assign vs_n   = (ln >= VS_LEN);
	assign vblank = (ln < VB_END) || (ln >= VB_START);

	always @(negedge clk_28) begin
		if (px == LINE_LEN - 1) begin
			px <= 0;
			if (ln == FRAME_LEN - 1) begin
				ln        <= 0;
				frame_cnt <= frame_cnt + 1; // frame end at vsync start
			end else begin
				ln <= ln + 1;
			end
		end else begin
			px <= px + 1;
		end
	end

	// de is stable at the falling edge
	always @(negedge clk_28) begin
		if (frame_cnt != mon_frame) begin
			mon_frame  <= frame_cnt;
			frame_runs <= run_cnt;
			frame_min  <= run_min;
			frame_max  <= run_max;
			run_len    <= 0;
			run_cnt    <= 0;
			run_min    <= 0;
			run_max    <= 0;
		end else if (de) begin
			run_len <= run_len + 1;
		end else if (run_len != 0) begin
			run_len <= 0; // end of a run
			run_cnt <= run_cnt + 1;
			if (run_cnt == 0 || run_len < run_min) run_min <= run_len;
			if (run_len > run_max) run_max <= run_len;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string tag, input string what, input int got,
		input int exp);
		$display("[ERROR] %0t: %s, %s is %0d, expected %0d", $time, tag, what, got, exp);
		val_errors++;
	endtask

	task automatic add_row(input logic [1:0] res_v, input int hl, input int hr, input int vt,
		input int vb, input int hsz, input int vsz, input int w, input int l, input int finc);
		row_nkeys[n_rows] = 0;
		row_res[n_rows]   = res_v;
		row_off[n_rows][0] = crop_pkg::crop_cnt_t'(hl);
		row_off[n_rows][1] = crop_pkg::crop_cnt_t'(hr);
		row_off[n_rows][2] = crop_pkg::crop_cnt_t'(vt);
		row_off[n_rows][3] = crop_pkg::crop_cnt_t'(vb);
		row_hsize[n_rows] = crop_pkg::crop_cnt_t'(hsz);
		row_vsize[n_rows] = crop_pkg::crop_cnt_t'(vsz);
		row_width[n_rows] = w;
		row_lines[n_rows] = l;
		row_finc[n_rows]  = flag_t'(finc);
		n_rows++;
	endtask

	task automatic add_key(input logic [1:0] kt, input logic [7:0] code);
		row_keys[n_rows - 1][row_nkeys[n_rows - 1]] = {kt, code};
		row_nkeys[n_rows - 1]++;
	endtask

	task automatic build_table();
		// res, hbl_l, hbl_r, vbl_t, vbl_b, hsize, vsize, width, lines, flag step
		add_row(2'd0, 0, 0, 0, 0, 64, 30, 64, 30, 0);
		add_row(2'd0, 8, 0, 0, 0, 64, 30, 56, 30, 0);
		add_key(ADJ, crop_pkg::KEY_LEFT);
		add_key(ADJ, crop_pkg::KEY_LEFT);
		add_row(2'd0, 8, 4, 0, 0, 64, 30, 60, 30, 0);
		add_key(ADJ, crop_pkg::KEY_ALT_L_DN);
		add_key(ADJ, crop_pkg::KEY_LEFT);
		add_key(ADJ, crop_pkg::KEY_ALT_L_UP);
		add_row(2'd0, 8, 4, 1, 0, 64, 30, 60, 29, 0);
		add_key(ADJ, crop_pkg::KEY_UP);
		add_row(2'd0, 8, 4, 1, 'hfff, 64, 30, 60, 28, 0); // vbl_b wraps
		add_key(ADJ, crop_pkg::KEY_ALT_R_DN);
		add_key(ADJ, crop_pkg::KEY_DOWN);
		add_key(ADJ, crop_pkg::KEY_ALT_R_UP);
		add_row(2'd0, 8, 4, 1, 'hfff, 64, 30, 60, 28, 0); // none of these may land
		add_key(2'd1, crop_pkg::KEY_LEFT);
		add_key(ADJ, 8'h20);
		add_key(2'd0, crop_pkg::KEY_UP);
		add_key(2'd2, crop_pkg::KEY_CLEAR);
		add_row(2'd0, 0, 0, 0, 0, 64, 30, 64, 30, 0);
		add_key(ADJ, crop_pkg::KEY_CLEAR);
		add_row(2'd2, 0, 0, 0, 0, 64, 30, 64, 30, 1); // mode change
		add_row(2'd2, 0, 0, 0, 0, 64, 30, 64, 30, 0);
	endtask

	task automatic send_key(input logic [9:0] k);
		int gap;
		gap        = 2 + ($random(seed) & 7);
		key_type   = k[9:8];
		key_data   = k[7:0];
		key_strobe = 1'b1;
		repeat (4) @(negedge clk_28);
		key_strobe = 1'b0;
		repeat (gap) @(negedge clk_28);
	endtask

	task automatic wait_frame_end();
		int start;
		int n;
		start = frame_cnt;
		n     = 0;
		while (frame_cnt == start && n < FRAME_TMO) begin
			@(negedge clk_28);
			n++;
		end
		if (frame_cnt == start) begin
			$display("Timed out at %0t waiting for the end of a frame", $time);
			tmo_errors++;
		end
	endtask

	task automatic apply_row(input int idx);
		string tag;
		flag_t flag_before;
		flag_t flag_step;
		int    k;
		tag         = $sformatf("row %0d", idx);
		flag_before = scr_flag;
		res         = row_res[idx];
		for (k = 0; k < row_nkeys[idx]; k++)
			send_key(row_keys[idx][k]);
		wait_frame_end();
		wait_frame_end(); // second frame runs wholly on the new offsets
		@(negedge clk_28);
		flag_step = scr_flag - flag_before;
		if (scr_hbl_l != row_off[idx][0])
			report_mismatch(tag, "scr_hbl_l", int'(scr_hbl_l), int'(row_off[idx][0]));
		if (scr_hbl_r != row_off[idx][1])
			report_mismatch(tag, "scr_hbl_r", int'(scr_hbl_r), int'(row_off[idx][1]));
		if (scr_vbl_t != row_off[idx][2])
			report_mismatch(tag, "scr_vbl_t", int'(scr_vbl_t), int'(row_off[idx][2]));
		if (scr_vbl_b != row_off[idx][3])
			report_mismatch(tag, "scr_vbl_b", int'(scr_vbl_b), int'(row_off[idx][3]));
		if (scr_hsize != row_hsize[idx])
			report_mismatch(tag, "scr_hsize", int'(scr_hsize), int'(row_hsize[idx]));
		if (scr_vsize != row_vsize[idx])
			report_mismatch(tag, "scr_vsize", int'(scr_vsize), int'(row_vsize[idx]));
		if (scr_res != row_res[idx])
			report_mismatch(tag, "scr_res", int'(scr_res), int'(row_res[idx]));
		// every active line carries one whole run
		if (frame_runs != row_lines[idx])
			report_mismatch(tag, "lines with de", frame_runs, row_lines[idx]);
		if (frame_min != row_width[idx])
			report_mismatch(tag, "shortest de run", frame_min, row_width[idx]);
		if (frame_max != row_width[idx])
			report_mismatch(tag, "longest de run", frame_max, row_width[idx]);
		if (flag_step != row_finc[idx])
			report_mismatch(tag, "scr_flag step", int'(flag_step), int'(row_finc[idx]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed       = 32'hb1eab183;
		rst_n      = 1'b0;
		res        = 2'd0;
		key_data   = 8'h00;
		key_type   = 2'd0;
		key_strobe = 1'b0;
		build_table();
		repeat (3) @(negedge clk_28);
		if (de !== 1'b0)
			report_mismatch("reset", "de", int'(de), 0);
		rst_n = 1'b1;

		wait_frame_end();
		wait_frame_end();
		@(negedge clk_28);
		if (scr_hbl_l != '0) report_mismatch("reset", "scr_hbl_l", int'(scr_hbl_l), 0);
		if (scr_hbl_r != '0) report_mismatch("reset", "scr_hbl_r", int'(scr_hbl_r), 0);
		if (scr_vbl_t != '0) report_mismatch("reset", "scr_vbl_t", int'(scr_vbl_t), 0);
		if (scr_vbl_b != '0) report_mismatch("reset", "scr_vbl_b", int'(scr_vbl_b), 0);
		if (scr_hsize != SRC_W)
			report_mismatch("reset", "scr_hsize", int'(scr_hsize), int'(SRC_W));
		if (scr_vsize != SRC_H)
			report_mismatch("reset", "scr_vsize", int'(scr_vsize), int'(SRC_H));
		wait_frame_end(); // let the flag settle after the first sizes

		for (r = 0; r < n_rows; r++)
			apply_row(r);

		$display("error counts: %0d wrong values, %0d timeouts", val_errors, tmo_errors);
		if (val_errors == 0 && tmo_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/crop_pkg.sv
rtl/crop_if.sv
rtl/margin_keys.sv
rtl/line_timing.sv
rtl/frame_timing.sv
rtl/mode_tracker.sv
rtl/video_crop.sv
test/tb_video_crop.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_video_crop
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
